//--- hw/memOrderPkg.sv
package memOrderPkg;

    // instruction, load and store sequence numbers share one width.
    typedef logic [6:0] SqN;

    typedef logic [4:0] FetchId;

    typedef logic [7:0] BranchHist;

    localparam int DEF_LB_ENTRIES = 24;

    // op as it leaves the issue stage.
    typedef struct packed {
        logic valid;
        logic isLoad;
        logic [31:0] base;
        logic signed [11:0] offset;
        logic [31:0] pc;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
        FetchId fetchId;
        BranchHist history;
    } IssueOp;

    // op after address generation.
    typedef struct packed {
        logic valid;
        logic isLoad;
        logic [31:0] addr;
        logic [31:0] pc;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
        FetchId fetchId;
        BranchHist history;
    } AguUOp;

    // pipeline redirect, restarts fetch at dstPc.
    typedef struct packed {
        logic taken;
        logic flush;
        logic [31:0] dstPc;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
        FetchId fetchId;
        BranchHist history;
    } BranchProv;

    // true when a is younger than b, sequence numbers wrap around.
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

//--- hw/addrGen.sv
`timescale 1ns/1ps

module addrGen (
    input logic clk,
    input logic rst,

    input memOrderPkg::IssueOp issueOp,
    input memOrderPkg::BranchProv redirect,

    output memOrderPkg::AguUOp aguOp
);

    import memOrderPkg::*;

    AguUOp opReg;
    logic [31:0] effAddr;
    logic [31:0] offsetExt;
    logic dropIn;
    logic killHeld;

    // effective address and squash of the incoming op.
    always_comb begin
        offsetExt = {{20{issueOp.offset[11]}}, issueOp.offset};
        effAddr = issueOp.base + offsetExt;
        dropIn = redirect.taken && isYounger(issueOp.sqN, redirect.sqN);
    end

    always_ff @(posedge clk) begin
        if (issueOp.valid) begin
            opReg.isLoad <= issueOp.isLoad;
            opReg.addr <= effAddr;
            opReg.pc <= issueOp.pc;
            opReg.sqN <= issueOp.sqN;
            opReg.loadSqN <= issueOp.loadSqN;
            opReg.storeSqN <= issueOp.storeSqN;
            opReg.fetchId <= issueOp.fetchId;
            opReg.history <= issueOp.history;
        end

        if (rst) begin
            opReg.valid <= 1'b0;
        end else begin
            opReg.valid <= issueOp.valid && !dropIn;
        end
    end

    // the held op dies if a redirect older than it arrives now.
    always_comb begin
        killHeld = redirect.taken && isYounger(opReg.sqN, redirect.sqN);
        aguOp = opReg;
        aguOp.valid = opReg.valid && !killHeld;
    end

endmodule

//--- hw/loadBuffer.sv
`timescale 1ns/1ps

module loadBuffer #(
    parameter int NUM_ENTRIES = 24
) (
    input logic clk,
    input logic rst,

    input memOrderPkg::SqN commitSqN,
    input memOrderPkg::AguUOp aguOp,
    input memOrderPkg::BranchProv redirect,

    output memOrderPkg::BranchProv violation,
    output memOrderPkg::SqN maxLoadSqN
);

    import memOrderPkg::*;

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    typedef struct packed {
        logic valid;
        SqN sqN;
        logic [29:0] wordAddr;
    } LbEntry;

    LbEntry entries [NUM_ENTRIES];
    LbEntry entriesNext [NUM_ENTRIES];

    // load sequence number held by entry 0.
    SqN baseSqN;
    SqN baseNext;
    SqN loadOff;
    logic [IDX_W-1:0] loadIdx;
    logic storeHit;

    always_comb begin
        entriesNext = entries;
        baseNext = baseSqN;

        if (redirect.taken) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (isYounger(entries[i].sqN, redirect.sqN)) begin
                    entriesNext[i].valid = 1'b0;
                end
            end
            if (redirect.flush) begin
                baseNext = redirect.loadSqN;
            end
        end else if (entries[0].valid && isYounger(commitSqN, entries[0].sqN)) begin
            // head load committed, shift the window by one.
            for (int i = 0; i < NUM_ENTRIES - 1; i++) begin
                entriesNext[i] = entries[i + 1];
            end
            entriesNext[NUM_ENTRIES - 1].valid = 1'b0;
            baseNext = baseSqN + 1'b1;
        end

        // slot is relative to the base after this cycle's shift.
        loadOff = aguOp.loadSqN - baseNext;
        loadIdx = loadOff[IDX_W-1:0];

        if (aguOp.valid && aguOp.isLoad) begin
            entriesNext[loadIdx].valid = 1'b1;
            entriesNext[loadIdx].sqN = aguOp.sqN;
            entriesNext[loadIdx].wordAddr = aguOp.addr[31:2];
        end
    end

    // a store hitting the word of a younger, already executed load.
    always_comb begin
        storeHit = 1'b0;
        if (aguOp.valid && !aguOp.isLoad) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (entries[i].valid && entries[i].wordAddr == aguOp.addr[31:2] &&
                        !isYounger(aguOp.sqN, entries[i].sqN)) begin
                    storeHit = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
            baseSqN <= '0;
            maxLoadSqN <= SqN'(NUM_ENTRIES - 1);
        end else begin
            entries <= entriesNext;
            baseSqN <= baseNext;
            maxLoadSqN <= baseSqN + SqN'(NUM_ENTRIES - 1);
        end
    end

    // restart at the store itself.
    always_ff @(posedge clk) begin
        if (storeHit) begin
            violation.flush <= 1'b0;
            violation.dstPc <= aguOp.pc;
            violation.sqN <= aguOp.sqN;
            violation.loadSqN <= aguOp.loadSqN;
            violation.storeSqN <= aguOp.storeSqN;
            violation.fetchId <= aguOp.fetchId;
            violation.history <= aguOp.history;
        end

        if (rst) begin
            violation.taken <= 1'b0;
        end else begin
            violation.taken <= storeHit;
        end
    end

    // the op source must keep loads inside the credit window.
    creditWindow: assert property (@(posedge clk) disable iff (rst)
        (aguOp.valid && aguOp.isLoad) |-> (loadOff < SqN'(NUM_ENTRIES)))
        else $error("load outside credit window");

    singleViolation: assert property (@(posedge clk) disable iff (rst)
        violation.taken |=> !(violation.taken && violation.sqN == $past(violation.sqN)))
        else $error("violation repeated for one store");

endmodule

//--- hw/redirectSelect.sv
`timescale 1ns/1ps

module redirectSelect (
    input logic clk,
    input logic rst,

    input memOrderPkg::BranchProv extBranch,
    input memOrderPkg::BranchProv violation,

    output memOrderPkg::BranchProv redirect
);

    import memOrderPkg::*;

    BranchProv chosen;
    logic violLive;
    logic pickViol;
    logic anyTaken;

    always_comb begin
        // a violation behind the redirect now going out is already squashed.
        violLive = violation.taken &&
            !(redirect.taken && isYounger(violation.sqN, redirect.sqN));

        // equal age goes to the branch.
        pickViol = violLive &&
            (!extBranch.taken || isYounger(extBranch.sqN, violation.sqN));

        anyTaken = violLive || extBranch.taken;
        chosen = pickViol ? violation : extBranch;
    end

    always_ff @(posedge clk) begin
        if (anyTaken) begin
            redirect.flush <= chosen.flush;
            redirect.dstPc <= chosen.dstPc;
            redirect.sqN <= chosen.sqN;
            redirect.loadSqN <= chosen.loadSqN;
            redirect.storeSqN <= chosen.storeSqN;
            redirect.fetchId <= chosen.fetchId;
            redirect.history <= chosen.history;
        end

        if (rst) begin
            redirect.taken <= 1'b0;
        end else begin
            redirect.taken <= anyTaken;
        end
    end

    // one redirect per restart point.
    singleRedirect: assert property (@(posedge clk) disable iff (rst)
        redirect.taken |=> !(redirect.taken && redirect.sqN == $past(redirect.sqN)))
        else $error("redirect repeated for one sqN");

endmodule

//--- hw/memOrderUnit.sv
`timescale 1ns/1ps

module memOrderUnit #(
    parameter int NUM_ENTRIES = memOrderPkg::DEF_LB_ENTRIES
) (
    input logic clk,
    input logic rst,

    input memOrderPkg::IssueOp issueOp,
    input memOrderPkg::SqN commitSqN,
    input memOrderPkg::BranchProv extBranch,

    output memOrderPkg::BranchProv redirect,
    output memOrderPkg::SqN maxLoadSqN
);

    import memOrderPkg::*;

    AguUOp aguOp;
    BranchProv violation;

    addrGen agu (
        .clk(clk),
        .rst(rst),
        .issueOp(issueOp),
        .redirect(redirect),
        .aguOp(aguOp)
    );

    // redirect feeds back as the squash.
    loadBuffer #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) lb (
        .clk(clk),
        .rst(rst),
        .commitSqN(commitSqN),
        .aguOp(aguOp),
        .redirect(redirect),
        .violation(violation),
        .maxLoadSqN(maxLoadSqN)
    );

    redirectSelect sel (
        .clk(clk),
        .rst(rst),
        .extBranch(extBranch),
        .violation(violation),
        .redirect(redirect)
    );

endmodule

//--- tb/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int HALF_NS = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- tb/memOrderTb.sv
`timescale 1ns/1ps

module memOrderTb;

    import memOrderPkg::*;

    localparam int MIN_VECS = 32;
    localparam int RESET_LIMIT = 100;
    localparam int DRAIN_LIMIT = 200;
    localparam logic [31:0] SEED = 32'hce1a_5f66;
    localparam BranchHist HIST = 8'h3c;

    // one cycle of inputs, with expected outputs and their care bits.
    // care[4] taken, care[3] flush, care[2] sqN, care[1] dstPc, care[0] maxLoadSqN.
    typedef struct packed {
        IssueOp op;
        SqN commit;
        BranchProv br;
        logic [4:0] care;
        logic expTaken;
        logic expFlush;
        SqN expSqN;
        logic [31:0] expDstPc;
        SqN expMax;
    } StimVec;

    logic clk;
    logic rst;
    IssueOp issueOp;
    SqN commitSqN;
    BranchProv extBranch;
    BranchProv redirect;
    SqN maxLoadSqN;

    StimVec vecs[$];

    clockGen #(
        .HALF_NS(10),
        .RESET_CYCLES(16)
    ) clkGen (
        .clk(clk),
        .rst(rst)
    );

    memOrderUnit #(
        .NUM_ENTRIES(DEF_LB_ENTRIES)
    ) dut (
        .clk(clk),
        .rst(rst),
        .issueOp(issueOp),
        .commitSqN(commitSqN),
        .extBranch(extBranch),
        .redirect(redirect),
        .maxLoadSqN(maxLoadSqN)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expVal,
            input logic [31:0] actVal);
        assert (actVal === expVal)
        else abortRun($sformatf("MISMATCH at %0t ns: %s expected %0h actual %0h",
            $time, name, expVal, actVal));
    endtask

    task automatic checkOutputs(input StimVec v);
        if (v.care[4]) begin
            checkValue("redirect.taken", 32'(v.expTaken), 32'(redirect.taken));
        end
        if (v.care[3]) begin
            checkValue("redirect.flush", 32'(v.expFlush), 32'(redirect.flush));
        end
        if (v.care[2]) begin
            checkValue("redirect.sqN", 32'(v.expSqN), 32'(redirect.sqN));
        end
        if (v.care[1]) begin
            checkValue("redirect.dstPc", v.expDstPc, redirect.dstPc);
        end
        // every op and branch carries its sqN low bits as fetchId and the fixed history.
        if (v.care[4] && v.expTaken && v.care[2]) begin
            checkValue("redirect.fetchId", 32'(v.expSqN[4:0]), 32'(redirect.fetchId));
            checkValue("redirect.history", 32'(HIST), 32'(redirect.history));
        end
        if (v.care[0]) begin
            checkValue("maxLoadSqN", 32'(v.expMax), 32'(maxLoadSqN));
        end
    endtask

    task automatic driveInputs(input StimVec v);
        issueOp = v.op;
        commitSqN = v.commit;
        extBranch = v.br;
    endtask

    // a dash marks a don't-care field.
    task automatic parseField(input string tok, output logic care, output logic [31:0] val);
        int n;
        care = 1'b0;
        val = '0;
        if (tok != "-") begin
            care = 1'b1;
            n = $sscanf(tok, "%h", val);
        end
    endtask

    task automatic readStimulus();
        int fd;
        int n;
        string line;
        string first;
        string t0, t1, t2, t3, t4;
        logic [31:0] f [14];
        logic care;
        logic [31:0] val;
        StimVec v;
        fd = $fopen("tb/memOrderStimulus.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open stimulus file tb/memOrderStimulus.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s", first) == 1 && first.getc(0) != "#") begin
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %s %s %s %s %s",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], t0, t1, t2, t3, t4);
                if (n != 19) begin
                    abortRun($sformatf("malformed stimulus line: %s", line));
                end
                v = '0;
                v.op.valid = f[0][0];
                v.op.isLoad = f[1][0];
                v.op.base = f[2];
                v.op.offset = f[3][11:0];
                v.op.pc = f[4];
                v.op.sqN = f[5][6:0];
                v.op.loadSqN = f[6][6:0];
                v.op.storeSqN = f[7][6:0];
                v.op.fetchId = f[5][4:0];
                v.op.history = HIST;
                v.commit = f[8][6:0];
                v.br.taken = f[9][0];
                v.br.flush = f[10][0];
                v.br.dstPc = f[11];
                v.br.sqN = f[12][6:0];
                v.br.loadSqN = f[13][6:0];
                v.br.fetchId = f[12][4:0];
                v.br.history = HIST;
                parseField(t0, care, val);
                v.care[4] = care;
                v.expTaken = val[0];
                parseField(t1, care, val);
                v.care[3] = care;
                v.expFlush = val[0];
                parseField(t2, care, val);
                v.care[2] = care;
                v.expSqN = val[6:0];
                parseField(t3, care, val);
                v.care[1] = care;
                v.expDstPc = val;
                parseField(t4, care, val);
                v.care[0] = care;
                v.expMax = val[6:0];
                vecs.push_back(v);
            end
        end
        $fclose(fd);
        if (vecs.size() < MIN_VECS) begin
            abortRun($sformatf("stimulus file holds %0d vectors but %0d are needed",
                vecs.size(), MIN_VECS));
        end
    endtask

    initial begin
        int waitCount;
        int seedVal;
        issueOp = '0;
        commitSqN = '0;
        extBranch = '0;
        seedVal = $urandom(SEED);
        readStimulus();

        waitCount = 0;
        @(posedge clk);
        while (rst && waitCount < RESET_LIMIT) begin
            @(posedge clk);
            waitCount++;
        end
        if (rst) begin
            abortRun("reset was not released in time");
        end

        // outputs of the previous line are checked before the next drive.
        for (int i = 0; i < vecs.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                checkOutputs(vecs[i - 1]);
            end
            driveInputs(vecs[i]);
        end
        @(negedge clk);
        checkOutputs(vecs[vecs.size() - 1]);
        issueOp = '0;
        extBranch = '0;

        waitCount = 0;
        while (redirect.taken && waitCount < DRAIN_LIMIT) begin
            @(negedge clk);
            waitCount++;
        end
        if (redirect.taken) begin
            abortRun("redirect still active 200 cycles after the last vector");
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- tb/memOrderStimulus.txt
# valid isLoad base offset pc sqN loadSqN storeSqN commitSqN brTaken brFlush brDstPc brSqN brLoadSqN
# then expected redirect taken flush sqN dstPc and maxLoadSqN, all hex, a dash is don't-care
0 0 00000000 000 00000000 00 00 00 00 0 0 00000000 00 00 0 - - - 17
0 0 00000000 000 00000000 00 00 00 00 0 0 00000000 00 00 0 - - - 17
1 1 00001000 010 00000200 0a 00 00 00 0 0 00000000 00 00 0 - - - 17
1 0 00001000 012 00000300 08 00 00 00 0 0 00000000 00 00 0 - - - 17
0 0 00000000 000 00000000 00 00 00 00 0 0 00000000 00 00 0 - - - 17
0 0 00000000 000 00000000 00 00 00 00 0 0 00000000 00 00 1 0 08 00000300 17
0 0 00000000 000 00000000 00 00 00 00 0 0 00000000 00 00 0 - - - 17
1 1 00001000 010 00000200 0a 00 00 00 0 0 00000000 00 00 0 - - - 17
1 0 00002000 000 00000300 08 00 00 00 0 0 00000000 00 00 0 - - - 17
1 0 00001000 013 00000400 0c 01 01 00 0 0 00000000 00 00 0 - - - 17
0 0 00000000 000 00000000 00 00 00 00 0 0 00000000 00 00 0 - - - 17
0 0 00000000 000 00000000 00 00 00 00 0 0 00000000 00 00 0 - - - 17
1 1 00003000 000 00000500 09 00 00 00 0 0 00000000 00 00 0 - - - 17
1 1 00003000 004 00000504 0a 01 00 00 0 0 00000000 00 00 0 - - - 17
1 1 00003000 008 00000508 0b 02 00 00 0 0 00000000 00 00 0 - - - 17
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 17
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 18
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 19
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 1a
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 1a
1 1 00004000 000 00000600 0f 03 00 0c 0 0 00000000 00 00 0 - - - 1a
0 0 00000000 000 00000000 00 00 00 0c 1 1 00000700 0c 06 1 1 0c 00000700 1a
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 1a
1 0 00004000 000 00000680 0d 06 00 0c 0 0 00000000 00 00 0 - - - 1d
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 1d
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 1d
1 1 00005000 008 00000880 16 06 02 0c 0 0 00000000 00 00 0 - - - 1d
1 0 00005000 00a 00000800 14 06 02 0c 0 0 00000000 00 00 0 - - - 1d
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 1d
0 0 00000000 000 00000000 00 00 00 0c 1 0 00000900 12 06 1 0 12 00000900 1d
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 1d
0 0 00000000 000 00000000 00 00 00 0c 0 0 00000000 00 00 0 - - - 1d

//--- vlog.f
hw/memOrderPkg.sv
hw/addrGen.sv
hw/loadBuffer.sv
hw/redirectSelect.sv
hw/memOrderUnit.sv
tb/clockGen.sv
tb/memOrderTb.sv

//--- Bender.yml
package:
  name: mem_order_unit

sources:
  - hw/memOrderPkg.sv
  - hw/addrGen.sv
  - hw/loadBuffer.sv
  - hw/redirectSelect.sv
  - hw/memOrderUnit.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/memOrderTb.sv
